// File: src/ex_defs.svh
// **************************************************
// ex_unit shared constants
// data width, register address width and the RV32
// opcode, funct3 and funct7 codes used by decode
// **************************************************

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN     32
`define EX_RADDR_W  5

// major opcodes
`define EX_OP_IMM    7'b0010011
`define EX_OP_REG    7'b0110011
`define EX_OP_BRANCH 7'b1100011
`define EX_OP_JAL    7'b1101111
`define EX_OP_JALR   7'b1100111
`define EX_OP_LUI    7'b0110111
`define EX_OP_AUIPC  7'b0010111

// alu group funct3
`define EX_F3_ADD  3'b000
`define EX_F3_SLL  3'b001
`define EX_F3_SLT  3'b010
`define EX_F3_SLTU 3'b011
`define EX_F3_XOR  3'b100
`define EX_F3_SR   3'b101       // srl / sra, split by bit 30
`define EX_F3_OR   3'b110
`define EX_F3_AND  3'b111

// branch group funct3
`define EX_F3_BEQ  3'b000
`define EX_F3_BNE  3'b001
`define EX_F3_BLT  3'b100
`define EX_F3_BGE  3'b101
`define EX_F3_BLTU 3'b110
`define EX_F3_BGEU 3'b111

// multiply group funct3
`define EX_F3_MUL    3'b000
`define EX_F3_MULH   3'b001
`define EX_F3_MULHSU 3'b010
`define EX_F3_MULHU  3'b011

`define EX_F7_BASE   7'b0000000
`define EX_F7_ALT    7'b0100000
`define EX_F7_MULDIV 7'b0000001

`endif

// File: src/ex_pkg.sv
// **************************************************
// ex_unit types
// operation enums and the records passed between
// the decode, compute and result stages
// **************************************************

`include "ex_defs.svh"

package ex_pkg;

    // which unit result feeds the writeback
    typedef enum logic [2:0] {
        cls_none   = 3'd0,
        cls_alu    = 3'd1,
        cls_mul    = 3'd2,
        cls_jump   = 3'd3,
        cls_branch = 3'd4,
        cls_pass   = 3'd5     // lui / auipc
    } ex_class_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_or   = 4'd5,
        alu_and  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } ex_alu_op_e;

    typedef struct packed {
        logic [31:0]              inst;
        logic [`EX_XLEN-1:0]      pc_next;
        logic                     reg_we;
        logic [`EX_RADDR_W-1:0]   reg_waddr;
        logic [`EX_XLEN-1:0]      op1;
        logic [`EX_XLEN-1:0]      op2;
        logic [`EX_XLEN-1:0]      cmp_a;    // branch compare operands
        logic [`EX_XLEN-1:0]      cmp_b;
    } ex_req_t;

    typedef struct packed {
        ex_class_e                cls;
        ex_alu_op_e               alu_op;
        logic [4:0]               shamt;
        logic [2:0]               f3;
        logic                     reg_we;
        logic [`EX_RADDR_W-1:0]   reg_waddr;
        logic [`EX_XLEN-1:0]      op1;
        logic [`EX_XLEN-1:0]      op2;
        logic [`EX_XLEN-1:0]      cmp_a;
        logic [`EX_XLEN-1:0]      cmp_b;
        logic [`EX_XLEN-1:0]      pc_next;
    } ex_dec_t;

    typedef struct packed {
        logic                     we;
        logic [`EX_RADDR_W-1:0]   waddr;
        logic [`EX_XLEN-1:0]      wdata;
    } ex_wb_t;

    typedef struct packed {
        logic                     flag;
        logic [`EX_XLEN-1:0]      addr;
    } ex_jump_t;

endpackage

// File: src/ex_decode.sv
// **************************************************
// ex_decode
// first pipeline stage, splits the instruction word
// into class and alu function and registers the
// decoded record with its operands
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_decode (
    input  logic             clk_i,
    input  logic             rst_i,
    input  ex_pkg::ex_req_t  req_i,
    output ex_pkg::ex_dec_t  dec_o
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ex_dec_t    dec_d;

    assign opcode = req_i.inst[6:0];
    assign funct3 = req_i.inst[14:12];
    assign funct7 = req_i.inst[31:25];

    always_comb begin
        dec_d           = '0;
        dec_d.cls       = cls_none;
        dec_d.alu_op    = alu_add;
        dec_d.shamt     = req_i.op2[4:0];    // register shifts
        dec_d.f3        = funct3;
        dec_d.reg_we    = req_i.reg_we;
        dec_d.reg_waddr = req_i.reg_waddr;
        dec_d.op1       = req_i.op1;
        dec_d.op2       = req_i.op2;
        dec_d.cmp_a     = req_i.cmp_a;
        dec_d.cmp_b     = req_i.cmp_b;
        dec_d.pc_next   = req_i.pc_next;

        case (opcode)
            `EX_OP_IMM: begin
                dec_d.cls   = cls_alu;
                dec_d.shamt = req_i.inst[24:20];
            end
            `EX_OP_REG: begin
                if (funct7 == `EX_F7_BASE || funct7 == `EX_F7_ALT) begin
                    dec_d.cls = cls_alu;
                end else if (funct7 == `EX_F7_MULDIV && !funct3[2]) begin
                    dec_d.cls = cls_mul;     // div/rem not supported
                end
            end
            `EX_OP_BRANCH: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    dec_d.cls = cls_branch;
                end
            end
            `EX_OP_JAL, `EX_OP_JALR:  dec_d.cls = cls_jump;
            `EX_OP_LUI, `EX_OP_AUIPC: dec_d.cls = cls_pass;
            default:                  dec_d.cls = cls_none;
        endcase

        // alu function, bit 30 picks sub and sra
        case (funct3)
            `EX_F3_ADD: begin
                if (opcode == `EX_OP_REG && req_i.inst[30]) dec_d.alu_op = alu_sub;
                else dec_d.alu_op = alu_add;    // addi has no sub form
            end
            `EX_F3_SLL:  dec_d.alu_op = alu_sll;
            `EX_F3_SLT:  dec_d.alu_op = alu_slt;
            `EX_F3_SLTU: dec_d.alu_op = alu_sltu;
            `EX_F3_XOR:  dec_d.alu_op = alu_xor;
            `EX_F3_SR:   dec_d.alu_op = req_i.inst[30] ? alu_sra : alu_srl;
            `EX_F3_OR:   dec_d.alu_op = alu_or;
            default:     dec_d.alu_op = alu_and;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_o <= '0;    // class none, no write
        end else begin
            dec_o <= dec_d;
        end
    end

endmodule

// File: src/ex_alu.sv
// **************************************************
// ex_alu
// combinational integer arithmetic, logic, compare
// and shift on the decoded operands
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_alu (
    input  ex_pkg::ex_dec_t          dec_i,
    output logic [`EX_XLEN-1:0]      res_o
);
    import ex_pkg::*;

    logic                        lt_s;
    logic                        lt_u;
    logic signed [`EX_XLEN-1:0]  op1_s;

    assign op1_s = dec_i.op1;

    // own compares for slt / sltu
    assign lt_s = $signed(dec_i.op1) < $signed(dec_i.op2);
    assign lt_u = dec_i.op1 < dec_i.op2;

    always_comb begin
        case (dec_i.alu_op)
            alu_add:  res_o = dec_i.op1 + dec_i.op2;
            alu_sub:  res_o = dec_i.op1 - dec_i.op2;
            alu_slt:  res_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
            alu_sltu: res_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
            alu_xor:  res_o = dec_i.op1 ^ dec_i.op2;
            alu_or:   res_o = dec_i.op1 | dec_i.op2;
            alu_and:  res_o = dec_i.op1 & dec_i.op2;
            alu_sll:  res_o = dec_i.op1 << dec_i.shamt;
            alu_srl:  res_o = dec_i.op1 >> dec_i.shamt;
            alu_sra:  res_o = op1_s >>> dec_i.shamt;    // sign fill
            default:  res_o = '0;
        endcase
    end

endmodule

// File: src/ex_multiplier.sv
// **************************************************
// ex_multiplier
// combinational 32x32 multiply for mul, mulh, mulhsu
// and mulhu, using magnitudes and a final negate
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_multiplier (
    input  ex_pkg::ex_dec_t          dec_i,
    output logic [`EX_XLEN-1:0]      res_o
);

    logic                        op1_signed;
    logic                        op2_signed;
    logic                        op1_neg;
    logic                        op2_neg;
    logic [`EX_XLEN-1:0]         mag1;
    logic [`EX_XLEN-1:0]         mag2;
    logic [2*`EX_XLEN-1:0]       prod;
    logic [2*`EX_XLEN-1:0]       prod_fix;

    assign op1_signed = (dec_i.f3 == `EX_F3_MULH) || (dec_i.f3 == `EX_F3_MULHSU);
    assign op2_signed = (dec_i.f3 == `EX_F3_MULH);

    assign op1_neg = op1_signed & dec_i.op1[`EX_XLEN-1];
    assign op2_neg = op2_signed & dec_i.op2[`EX_XLEN-1];

    assign mag1 = op1_neg ? (~dec_i.op1 + 1'b1) : dec_i.op1;
    assign mag2 = op2_neg ? (~dec_i.op2 + 1'b1) : dec_i.op2;

    assign prod = {{`EX_XLEN{1'b0}}, mag1} * {{`EX_XLEN{1'b0}}, mag2};

    // sign correction when exactly one operand was negative
    assign prod_fix = (op1_neg ^ op2_neg) ? (~prod + 1'b1) : prod;

    always_comb begin
        case (dec_i.f3)
            `EX_F3_MUL:                                 res_o = prod_fix[`EX_XLEN-1:0];
            `EX_F3_MULH, `EX_F3_MULHSU, `EX_F3_MULHU:   res_o = prod_fix[2*`EX_XLEN-1:`EX_XLEN];
            default:                                    res_o = '0;
        endcase
    end

endmodule

// File: src/ex_branch.sv
// **************************************************
// ex_branch
// branch condition on cmp_a/cmp_b and jump target
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_branch (
    input  ex_pkg::ex_dec_t          dec_i,
    output logic                     taken_o,
    output logic [`EX_XLEN-1:0]      target_o
);
    import ex_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = dec_i.cmp_a == dec_i.cmp_b;
    assign lt_s = $signed(dec_i.cmp_a) < $signed(dec_i.cmp_b);
    assign lt_u = dec_i.cmp_a < dec_i.cmp_b;

    always_comb begin
        case (dec_i.f3)
            `EX_F3_BEQ:  cond = eq;
            `EX_F3_BNE:  cond = ~eq;
            `EX_F3_BLT:  cond = lt_s;
            `EX_F3_BGE:  cond = ~lt_s;
            `EX_F3_BLTU: cond = lt_u;
            `EX_F3_BGEU: cond = ~lt_u;
            default:     cond = 1'b0;
        endcase
    end

    // jal/jalr always redirect
    assign taken_o  = ((dec_i.cls == cls_branch) && cond) || (dec_i.cls == cls_jump);
    assign target_o = taken_o ? (dec_i.op1 + dec_i.op2) : '0;

endmodule

// File: src/ex_result.sv
// **************************************************
// ex_result
// second pipeline stage, picks the write data by
// class and registers writeback and jump outputs
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_result (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  ex_pkg::ex_dec_t          dec_i,
    input  logic [`EX_XLEN-1:0]      alu_res_i,
    input  logic [`EX_XLEN-1:0]      mul_res_i,
    input  logic                     taken_i,
    input  logic [`EX_XLEN-1:0]      target_i,
    output ex_pkg::ex_wb_t           wb_o,
    output ex_pkg::ex_jump_t         jump_o
);
    import ex_pkg::*;

    logic [`EX_XLEN-1:0] wdata;

    always_comb begin
        case (dec_i.cls)
            cls_alu:  wdata = alu_res_i;
            cls_mul:  wdata = mul_res_i;
            cls_jump: wdata = dec_i.pc_next;             // return address
            cls_pass: wdata = dec_i.op1 + dec_i.op2;     // lui / auipc
            default:  wdata = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o   <= '0;
            jump_o <= '0;
        end else begin
            wb_o.we     <= dec_i.reg_we;
            wb_o.waddr  <= dec_i.reg_waddr;
            wb_o.wdata  <= wdata;
            jump_o.flag <= taken_i;
            jump_o.addr <= target_i;
        end
    end

endmodule

// File: src/ex_unit.sv
// **************************************************
// ex_unit
// two-stage integer execute unit for RV32: decode
// register, alu/multiplier/branch, result register
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    input  ex_pkg::ex_req_t   req_i,
    output ex_pkg::ex_wb_t    wb_o,
    output ex_pkg::ex_jump_t  jump_o
);
    import ex_pkg::*;

    ex_dec_t             dec;
    logic [`EX_XLEN-1:0] alu_res;
    logic [`EX_XLEN-1:0] mul_res;
    logic                taken;
    logic [`EX_XLEN-1:0] target;

    ex_decode u_decode (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (req_i),
        .dec_o (dec)
    );

    ex_alu u_alu (
        .dec_i (dec),
        .res_o (alu_res)
    );

    ex_multiplier u_mul (
        .dec_i (dec),
        .res_o (mul_res)
    );

    ex_branch u_branch (
        .dec_i    (dec),
        .taken_o  (taken),
        .target_o (target)
    );

    ex_result u_result (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .dec_i     (dec),
        .alu_res_i (alu_res),
        .mul_res_i (mul_res),
        .taken_i   (taken),
        .target_i  (target),
        .wb_o      (wb_o),
        .jump_o    (jump_o)
    );

endmodule

// File: sim/tb_ex_unit.sv
// **************************************************
// tb_ex_unit
// trace-driven testbench for the execute unit, with
// random bubbles and checks two edges after issue
// **************************************************

`timescale 1ns/10ps
`include "ex_defs.svh"

module tb_ex_unit;
    import ex_pkg::*;

    localparam int FIELDS    = 13;      // words per trace line
    localparam int MAX_LINES = 64;
    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 40;      // cycles per wait

    logic     clk_i = 1'b0;
    logic     rst_i;
    ex_req_t  req_i;
    ex_wb_t   wb_o;
    ex_jump_t jump_o;

    logic [31:0] trace_mem [0:MEM_WORDS-1];
    ex_wb_t      exp_wb_q [$];
    ex_jump_t    exp_jump_q [$];
    int          due_q [$];
    string       name_q [$];
    ex_wb_t      exp_wb;
    ex_jump_t    exp_jump;
    string       name;
    int          cyc = 0;
    int          err_wb = 0;
    int          err_jump = 0;
    int          err_flow = 0;
    logic [7:0]  lfsr = 8'd8;
    logic        abort = 1'b0;

    ex_unit u_dut (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .wb_o   (wb_o),
        .jump_o (jump_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    // taps x^8 + x^6 + x^5 + x^4 + 1 with the new bit entering at bit 0
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return 32'hbad00000 ^ addr;
    endfunction

    task automatic check_wb(input ex_wb_t got, input ex_wb_t exp, input string what);
        if (got !== exp) begin
            err_wb++;
            $display("Fail at %0d ns: %s writeback we=%0b waddr=%0d wdata=%h, expected %0b %0d %h",
                     $time, what, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
        end
    endtask

    task automatic check_jump(input ex_jump_t got, input ex_jump_t exp, input string what);
        if (got !== exp) begin
            err_jump++;
            $display("Fail at %0d ns: %s jump flag=%0b addr=%h, expected %0b %h",
                     $time, what, got.flag, got.addr, exp.flag, exp.addr);
        end
    endtask

    // result of a request issued at edge e is registered at edge e+2
    task automatic issue(input ex_req_t r, input ex_wb_t ew, input ex_jump_t ej, input string s);
        @(posedge clk_i);
        #1;
        req_i = r;
        exp_wb_q.push_back(ew);
        exp_jump_q.push_back(ej);
        name_q.push_back(s);
        due_q.push_back(cyc + 2);
    endtask

    task automatic read_line(input int i, output ex_req_t r, output ex_wb_t ew,
                             output ex_jump_t ej);
        int b;
        b           = 1 + i * FIELDS;
        r.inst      = trace_mem[b];
        r.pc_next   = trace_mem[b+1];
        r.reg_we    = trace_mem[b+2][0];
        r.reg_waddr = trace_mem[b+3][`EX_RADDR_W-1:0];
        r.op1       = trace_mem[b+4];
        r.op2       = trace_mem[b+5];
        r.cmp_a     = trace_mem[b+6];
        r.cmp_b     = trace_mem[b+7];
        ew.we       = trace_mem[b+8][0];
        ew.waddr    = trace_mem[b+9][`EX_RADDR_W-1:0];
        ew.wdata    = trace_mem[b+10];
        ej.flag     = trace_mem[b+11][0];
        ej.addr     = trace_mem[b+12];
    endtask

    task automatic wait_drain(input string what);
        int guard;
        guard = 0;
        while (due_q.size() > 0 && guard < TIMEOUT) begin
            @(posedge clk_i);
            guard++;
        end
        if (due_q.size() > 0) begin
            $display("Timeout while waiting for %s, %0d results never checked",
                     what, due_q.size());
            err_flow++;
            abort = 1'b1;
        end
    endtask

    always @(negedge clk_i) begin
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            exp_wb   = exp_wb_q.pop_front();
            exp_jump = exp_jump_q.pop_front();
            name     = name_q.pop_front();
            void'(due_q.pop_front());
            check_wb(wb_o, exp_wb, name);
            check_jump(jump_o, exp_jump, name);
        end
    end

    initial begin
        int       fd;
        int       n_lines;
        ex_req_t  r;
        ex_wb_t   ew;
        ex_jump_t ej;

        rst_i   = 1'b1;
        req_i   = '0;
        n_lines = 0;
        for (int a = 0; a < MEM_WORDS; a++) trace_mem[a] = fill_word(a);

        fd = $fopen("sim/ex_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/ex_trace.txt");
            err_flow++;
            abort = 1'b1;
        end else begin
            $fclose(fd);
            $readmemh("sim/ex_trace.txt", trace_mem);
            n_lines = trace_mem[0];
            if (n_lines < 1 || n_lines > MAX_LINES) begin
                $display("The trace file has no valid line count");
                err_flow++;
                abort = 1'b1;
            end else if (trace_mem[n_lines*FIELDS] == fill_word(n_lines * FIELDS)) begin
                $display("The trace file holds fewer lines than its count says");
                err_flow++;
                abort = 1'b1;
            end
        end

        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // outputs still hold their reset values in this cycle
        exp_wb_q.push_back('0);
        exp_jump_q.push_back('0);
        name_q.push_back("after reset");
        due_q.push_back(cyc);
        wait_drain("the reset check");

        if (!abort) begin
            for (int i = 0; i < n_lines; i++) begin
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) issue('0, '0, '0, "bubble");
                read_line(i, r, ew, ej);
                issue(r, ew, ej, $sformatf("trace line %0d", i + 1));
            end
            wait_drain("the end of the trace");
        end

        $display("errors: writeback %0d, jump %0d, other %0d", err_wb, err_jump, err_flow);
        if (err_wb + err_jump + err_flow == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: ex_unit.f
+incdir+src
src/ex_pkg.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_multiplier.sv
src/ex_branch.sv
src/ex_result.sv
src/ex_unit.sv
sim/tb_ex_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ex_unit testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
log=sim_run.log
rm -f "$log"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_ex_unit \
    -f ex_unit.f --Mdir obj_dir -o tb_ex_unit \
    && ./obj_dir/tb_ex_unit | tee "$log" \
    || { echo "build or simulation failed"; exit 1; }
grep -q "Done: no errors" "$log" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/ex_trace.txt
// inst pc_next we waddr op1 op2 cmp_a cmp_b, then expected we waddr wdata jump_flag jump_addr
// first word is the number of trace lines, all values hex
00000025
003100B3 00000104 1 01 00001234 00000ABC 00000000 00000000 1 01 00001CF0 0 00000000
403100B3 00000104 1 02 00000005 00000007 00000000 00000000 1 02 FFFFFFFE 0 00000000
003120B3 00000104 1 03 FFFFFFF0 00000001 00000000 00000000 1 03 00000001 0 00000000
003130B3 00000104 1 04 FFFFFFF0 00000001 00000000 00000000 1 04 00000000 0 00000000
003140B3 00000104 1 05 F0F0F0F0 0FF00FF0 00000000 00000000 1 05 FF00FF00 0 00000000
003160B3 00000104 1 06 12340000 00005678 00000000 00000000 1 06 12345678 0 00000000
003170B3 00000104 1 07 FF00FF00 0F0F0F0F 00000000 00000000 1 07 0F000F00 0 00000000
003110B3 00000104 1 08 00000003 00000024 00000000 00000000 1 08 00000030 0 00000000
003150B3 00000104 1 09 80000000 00000004 00000000 00000000 1 09 08000000 0 00000000
403150B3 00000104 1 0A 80000000 00000004 00000000 00000000 1 0A F8000000 0 00000000
403150B3 00000104 1 0B FFFF0000 0000001F 00000000 00000000 1 0B FFFFFFFF 0 00000000
FFF10093 00000104 1 0C 00000010 FFFFFFFF 00000000 00000000 1 0C 0000000F 0 00000000
FFF12093 00000104 1 0D FFFFFFFE FFFFFFFF 00000000 00000000 1 0D 00000001 0 00000000
FFF13093 00000104 1 0E 00000005 FFFFFFFF 00000000 00000000 1 0E 00000001 0 00000000
00411093 00000104 1 0F 0000ABCD 00000004 00000000 00000000 1 0F 000ABCD0 0 00000000
40815093 00000104 1 10 87654321 00000408 00000000 00000000 1 10 FF876543 0 00000000
023100B3 00000104 1 11 00001234 00005678 00000000 00000000 1 11 06260060 0 00000000
023100B3 00000104 1 12 FFFFFFFE 00000003 00000000 00000000 1 12 FFFFFFFA 0 00000000
023110B3 00000104 1 13 FFFFFFFE 00000003 00000000 00000000 1 13 FFFFFFFF 0 00000000
023110B3 00000104 1 14 80000000 80000000 00000000 00000000 1 14 40000000 0 00000000
023120B3 00000104 1 15 FFFFFFFF FFFFFFFF 00000000 00000000 1 15 FFFFFFFF 0 00000000
023120B3 00000104 1 16 00000002 80000000 00000000 00000000 1 16 00000001 0 00000000
023130B3 00000104 1 17 FFFFFFFF FFFFFFFF 00000000 00000000 1 17 FFFFFFFE 0 00000000
023130B3 00000104 1 18 80000000 00000004 00000000 00000000 1 18 00000002 0 00000000
00310063 00000104 0 00 00001000 00000020 00000055 00000055 0 00 00000000 1 00001020
00310063 00000104 0 00 00001000 00000020 00000055 00000056 0 00 00000000 0 00000000
00311063 00000104 0 00 00002000 FFFFFFF0 00000001 00000002 0 00 00000000 1 00001FF0
00314063 00000104 0 00 00003000 00000100 FFFFFFFF 00000001 0 00 00000000 1 00003100
00316063 00000104 0 00 00003000 00000100 FFFFFFFF 00000001 0 00 00000000 0 00000000
00315063 00000104 0 00 00004000 00000008 00000001 FFFFFFFF 0 00 00000000 1 00004008
00315063 00000104 0 00 00004000 00000008 80000000 00000000 0 00 00000000 0 00000000
00317063 00000104 0 00 00005000 00000010 80000000 00000000 0 00 00000000 1 00005010
008000EF 00000104 1 01 00000100 00000008 00000000 00000000 1 01 00000104 1 00000108
000100E7 00000208 1 05 00008000 00000010 00000000 00000000 1 05 00000208 1 00008010
123450B7 00000104 1 0A 12345000 00000000 00000000 00000000 1 0A 12345000 0 00000000
00001097 00000204 1 0B 00000200 00001000 00000000 00000000 1 0B 00001200 0 00000000
0000008B 00000104 1 03 11111111 22222222 00000000 00000000 1 03 00000000 0 00000000
